//--- sources.f
verilog/cpu_pkg.sv
verilog/insn_decoder.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/scoreboard.sv
verilog/issue_select.sv
verilog/exec_pipe.sv
verilog/superscalar_core.sv
dv/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
    -f sources.f -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/core_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- dv/core_tb.sv
`timescale 1ns/1ps

module core_tb;
    import cpu_pkg::*;

    localparam int MEM_DEPTH   = 256;
    localparam int TIMEOUT_CYC = 2000;
    localparam int RST_CYCLES  = 3;

    logic       clk;
    logic       rst;
    insn_vec_t  fetch_insn;
    pc_t        fetch_pc;
    wb_vec_t    wb;
    issue_cnt_t issue_cnt;

    insn_t    imem [MEM_DEPTH];
    insn_t    prog [$];
    reg_idx_t exp_rd_q [$];
    word_t    exp_data_q [$];
    word_t    model_regs [NUM_REGS];

    // expected result per lane for the current writeback cycle
    logic     [ISSUE_WIDTH-1:0] has_exp;
    reg_idx_t [ISSUE_WIDTH-1:0] exp_rd;
    word_t    [ISSUE_WIDTH-1:0] exp_data;
    logic                       any_valid;
    logic                       dup_rd;
    issue_cnt_t                 max_cnt;

    integer seed   = 32'h7ae70423;
    int     errors = 0;
    int     checks = 0;
    int     tests  = 0;

    superscalar_core DUT (
        .clk          (clk),
        .rst          (rst),
        .fetch_insn_i (fetch_insn),
        .fetch_pc_o   (fetch_pc),
        .wb_o         (wb),
        .issue_cnt_o  (issue_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction memory, four words from the fetch pc on
    always_comb begin
        int unsigned addr;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            addr = fetch_pc + k;
            fetch_insn[k] = (addr < MEM_DEPTH) ? imem[addr] : NOP_INSN;
        end
    end

    always_comb begin
        any_valid = 1'b0;
        dup_rd    = 1'b0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            any_valid = any_valid | wb[i].valid;
            for (int j = i + 1; j < ISSUE_WIDTH; j++) begin
                if (wb[i].valid && wb[j].valid && wb[i].rd == wb[j].rd) begin
                    dup_rd = 1'b1;
                end
            end
        end
    end

    // lanes retire in program order, lowest lane first
    always @(negedge clk) begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            has_exp[k]  = 1'b0;
            exp_rd[k]   = '0;
            exp_data[k] = '0;
            if (!rst && wb[k].valid && exp_rd_q.size() > 0) begin
                has_exp[k]  = 1'b1;
                exp_rd[k]   = exp_rd_q.pop_front();
                exp_data[k] = exp_data_q.pop_front();
                checks++;
            end
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            max_cnt <= '0;
        end else if (issue_cnt > max_cnt) begin
            max_cnt <= issue_cnt;
        end
    end

    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_lane_chk
        a_expected: assert property (@(posedge clk) disable iff (rst)
            wb[k].valid |-> (has_exp[k] && wb[k].rd != '0))
            else begin
                $display("lane %0d wrote x%0d at %0t but no such result was expected",
                         k, $sampled(wb[k].rd), $time);
                errors++;
            end
        a_value: assert property (@(posedge clk) disable iff (rst)
            (wb[k].valid && has_exp[k]) |-> (wb[k].rd == exp_rd[k] && wb[k].data == exp_data[k]))
            else begin
                $display("MISMATCH at %0t: lane %0d got x%0d=%h, expected x%0d=%h", $time, k,
                         $sampled(wb[k].rd), $sampled(wb[k].data),
                         $sampled(exp_rd[k]), $sampled(exp_data[k]));
                errors++;
            end
    end

    a_no_dup: assert property (@(posedge clk) disable iff (rst) !dup_rd)
        else begin
            $display("two writeback lanes hit the same register at %0t", $time);
            errors++;
        end

    a_reset_state: assert property (@(posedge clk)
        (rst || $past(rst)) |-> (fetch_pc == '0 && !any_valid))
        else begin
            $display("fetch pc or writeback lanes not cleared by reset at %0t", $time);
            errors++;
        end

    a_pc_step: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (fetch_pc >= $past(fetch_pc)
                         && fetch_pc - $past(fetch_pc) <= pc_t'(ISSUE_WIDTH)))
        else begin
            $display("fetch pc went backwards or jumped too far at %0t", $time);
            errors++;
        end

    a_cnt_match: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (fetch_pc == $past(fetch_pc) + pc_t'($past(issue_cnt))))
        else begin
            $display("fetch pc advance differs from the issue count at %0t", $time);
            errors++;
        end

    function automatic insn_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     funct3_t f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic insn_t i_type(logic [11:0] imm, reg_idx_t rs1, funct3_t f3, reg_idx_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic insn_t random_alu(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        int unsigned pick;
        logic [11:0] imm;
        funct3_t     f3;
        pick = {$random(seed)} % 18;
        imm  = 12'($random(seed));
        if (pick < 8) begin
            return r_type(7'h00, rs2, rs1, funct3_t'(pick), rd);
        end else if (pick == 8) begin
            return r_type(7'h20, rs2, rs1, 3'b000, rd);
        end else if (pick == 9) begin
            return r_type(7'h20, rs2, rs1, 3'b101, rd);
        end
        f3 = funct3_t'(pick - 10);
        // shift immediates hold shamt and the srai bit only
        if (f3 == 3'b001) begin
            imm = {7'h00, imm[4:0]};
        end else if (f3 == 3'b101) begin
            imm = {1'b0, imm[10], 5'h00, imm[4:0]};
        end
        return i_type(imm, rs1, f3, rd);
    endfunction

    // sequential RV32I semantics, one instruction at a time
    function automatic void model_step(insn_t insn);
        funct3_t  f3;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    res;
        logic     alt;
        f3  = insn[14:12];
        rd  = insn[11:7];
        alt = insn[30];
        a   = model_regs[insn[19:15]];
        if (insn[6:0] == OPC_OP) begin
            b = model_regs[insn[24:20]];
        end else if (insn[6:0] == OPC_OP_IMM) begin
            b   = {{20{insn[31]}}, insn[31:20]};
            alt = alt && (f3 == 3'b101);
        end else begin
            return;
        end
        case (f3)
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        if (rd != '0) begin
            model_regs[rd] = res;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
        end
    endfunction

    task automatic load_program();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : NOP_INSN;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        exp_rd_q.delete();
        exp_data_q.delete();
        foreach (prog[i]) begin
            model_step(prog[i]);
        end
    endtask

    // starts on a falling edge, ends on the next falling edge after draining
    task automatic run_test(string name, logic need_full_issue);
        int err_start;
        int chk_start;
        int cyc;
        err_start = errors;
        chk_start = checks;
        rst = 1'b1;
        load_program();
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        cyc = 0;
        while (!(fetch_pc >= prog.size() && exp_rd_q.size() == 0) && cyc < TIMEOUT_CYC) begin
            @(posedge clk);
            cyc++;
        end
        @(negedge clk);
        if (cyc >= TIMEOUT_CYC) begin
            $display("test %0s timed out with %0d results never written back",
                     name, exp_rd_q.size());
            errors++;
        end
        if (need_full_issue) begin
            a_full_issue: assert (max_cnt == ISSUE_WIDTH)
                else begin
                    $display("issue count never reached the issue width in test %0s", name);
                    errors++;
                end
        end
        tests++;
        $display("test %0s: %0d results checked, %0d errors",
                 name, checks - chk_start, errors - err_start);
    endtask

    task automatic build_independent();
        prog.delete();
        for (int r = 1; r < 8; r++) begin
            prog.push_back(i_type(12'($random(seed)), 5'd0, 3'b000, reg_idx_t'(r)));
        end
        // destinations never feed a later source in this block
        for (int i = 0; i < 24; i++) begin
            prog.push_back(random_alu(reg_idx_t'(8 + i), reg_idx_t'(1 + {$random(seed)} % 7),
                                      reg_idx_t'(1 + {$random(seed)} % 7)));
        end
    endtask

    task automatic build_group_deps();
        prog.delete();
        for (int g = 0; g < 6; g++) begin
            prog.push_back(i_type(12'($random(seed)), 5'd0, 3'b000, 5'd1));
            prog.push_back(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
            prog.push_back(i_type(12'($random(seed)), 5'd2, 3'b100, 5'd3));
            prog.push_back(i_type(12'($random(seed)), 5'd1, 3'b000, 5'd3));
        end
        for (int i = 0; i < 16; i++) begin
            prog.push_back(random_alu(reg_idx_t'(1 + {$random(seed)} % 4),
                                      reg_idx_t'(1 + {$random(seed)} % 4),
                                      reg_idx_t'(1 + {$random(seed)} % 4)));
        end
    endtask

    task automatic build_chains();
        prog.delete();
        prog.push_back(i_type(12'($random(seed)), 5'd0, 3'b000, 5'd5));
        for (int i = 0; i < 12; i++) begin
            prog.push_back(random_alu(reg_idx_t'(6 + i), reg_idx_t'(5 + i),
                                      reg_idx_t'(5 + {$random(seed)} % (i + 1))));
        end
        for (int i = 0; i < 8; i++) begin
            prog.push_back(i_type(12'd3, 5'd5, 3'b000, 5'd5));
        end
    endtask

    task automatic build_imm_shift();
        prog.delete();
        prog.push_back(i_type(12'hfff, 5'd0, 3'b000, 5'd1));
        prog.push_back(i_type(12'h800, 5'd0, 3'b000, 5'd2));
        prog.push_back(i_type(12'h7ff, 5'd0, 3'b000, 5'd3));
        prog.push_back(i_type(12'h000, 5'd1, 3'b010, 5'd4));
        prog.push_back(i_type(12'hfff, 5'd1, 3'b010, 5'd5));
        prog.push_back(i_type(12'hfff, 5'd3, 3'b011, 5'd6));
        prog.push_back(i_type(12'hfff, 5'd1, 3'b011, 5'd7));
        prog.push_back(i_type(12'h001, 5'd0, 3'b011, 5'd8));
        prog.push_back(i_type({7'h20, 5'd4}, 5'd2, 3'b101, 5'd9));
        prog.push_back(i_type({7'h00, 5'd4}, 5'd2, 3'b101, 5'd10));
        prog.push_back(i_type({7'h20, 5'd31}, 5'd1, 3'b101, 5'd11));
        prog.push_back(i_type({7'h00, 5'd31}, 5'd1, 3'b101, 5'd12));
        prog.push_back(i_type(12'hfff, 5'd3, 3'b100, 5'd13));
        prog.push_back(r_type(7'h20, 5'd3, 5'd2, 3'b101, 5'd14));
        prog.push_back(r_type(7'h00, 5'd3, 5'd2, 3'b010, 5'd15));
        prog.push_back(r_type(7'h00, 5'd3, 5'd2, 3'b011, 5'd16));
    endtask

    task automatic build_x0();
        prog.delete();
        prog.push_back(i_type(12'd9, 5'd0, 3'b000, 5'd1));
        prog.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd0));
        prog.push_back(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        prog.push_back(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd2));
        // system opcode, decodes as a bubble
        prog.push_back(32'h0000_0073);
        prog.push_back(i_type(12'hff9, 5'd0, 3'b000, 5'd3));
        prog.push_back(r_type(7'h20, 5'd1, 5'd0, 3'b000, 5'd4));
        prog.push_back(r_type(7'h00, 5'd3, 5'd3, 3'b110, 5'd0));
    endtask

    initial begin
        rst = 1'b1;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            imem[i] = NOP_INSN;
        end
        @(negedge clk);
        build_independent();
        run_test("independent", 1'b1);
        build_group_deps();
        run_test("group_deps", 1'b0);
        build_chains();
        run_test("chains", 1'b0);
        build_imm_shift();
        run_test("imm_shift", 1'b0);
        build_x0();
        run_test("x0_reset", 1'b0);
        $display("%0d tests, %0d results checked, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog/superscalar_core.sv
`timescale 1ns/1ps

module superscalar_core (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::insn_vec_t  fetch_insn_i,
    output cpu_pkg::pc_t        fetch_pc_o,
    output cpu_pkg::wb_vec_t    wb_o,
    output cpu_pkg::issue_cnt_t issue_cnt_o
);
    import cpu_pkg::*;

    pc_t                          pc_q;
    dec_vec_t                     dec;
    reg_idx_t [ISSUE_WIDTH-1:0]   rs1_idx;
    reg_idx_t [ISSUE_WIDTH-1:0]   rs2_idx;
    word_t    [ISSUE_WIDTH-1:0]   rs1_data;
    word_t    [ISSUE_WIDTH-1:0]   rs2_data;
    issue_mask_t                  sb_clear;
    issue_mask_t                  issue_mask;
    issue_cnt_t                   issue_cnt;
    wb_vec_t                      wb;

    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_dec
        insn_decoder u_dec (
            .insn_i (fetch_insn_i[k]),
            .dec_o  (dec[k])
        );

        assign rs1_idx[k] = dec[k].rs1;
        assign rs2_idx[k] = dec[k].rs2;
    end

    reg_file u_rf (
        .clk        (clk),
        .rst        (rst),
        .rs1_i      (rs1_idx),
        .rs2_i      (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb)
    );

    scoreboard u_sb (
        .clk          (clk),
        .rst          (rst),
        .dec_i        (dec),
        .issue_mask_i (issue_mask),
        .clear_o      (sb_clear)
    );

    issue_select u_issue (
        .dec_i        (dec),
        .clear_i      (sb_clear),
        .issue_mask_o (issue_mask),
        .issue_cnt_o  (issue_cnt)
    );

    exec_pipe u_exec (
        .clk          (clk),
        .rst          (rst),
        .dec_i        (dec),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .issue_mask_i (issue_mask),
        .wb_o         (wb)
    );

    // unissued slots are simply fetched again from the new pc
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_q + pc_t'(issue_cnt);
        end
    end

    assign fetch_pc_o  = pc_q;
    assign wb_o        = wb;
    assign issue_cnt_o = issue_cnt;

    a_pc_step: assert property (@(posedge clk) disable iff (rst)
        (pc_q - $past(pc_q)) <= pc_t'(ISSUE_WIDTH))
        else $error("pc advanced by more than the issue width");

endmodule

//--- verilog/exec_pipe.sv
`timescale 1ns/1ps

module exec_pipe (
    input  logic                                         clk,
    input  logic                                         rst,
    input  cpu_pkg::dec_vec_t                            dec_i,
    input  cpu_pkg::word_t [cpu_pkg::ISSUE_WIDTH-1:0]    rs1_data_i,
    input  cpu_pkg::word_t [cpu_pkg::ISSUE_WIDTH-1:0]    rs2_data_i,
    input  cpu_pkg::issue_mask_t                         issue_mask_i,
    output cpu_pkg::wb_vec_t                             wb_o
);
    import cpu_pkg::*;

    ex_t     [ISSUE_WIDTH-1:0] ex_d;
    ex_t     [ISSUE_WIDTH-1:0] ex_q;
    word_t   [ISSUE_WIDTH-1:0] op_b;
    word_t   [ISSUE_WIDTH-1:0] alu_res;
    wb_vec_t                   wb_d;
    wb_vec_t                   wb_q;

    // blocked slots go in as bubbles
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            ex_d[k].valid     = issue_mask_i[k];
            ex_d[k].rd        = dec_i[k].rd;
            ex_d[k].reg_write = dec_i[k].reg_write;
            ex_d[k].op_b_sel  = dec_i[k].op_b_sel;
            ex_d[k].alu_op    = dec_i[k].alu_op;
            ex_d[k].imm       = dec_i[k].imm;
            ex_d[k].rs1_data  = rs1_data_i[k];
            ex_d[k].rs2_data  = rs2_data_i[k];
        end
    end

    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_lane
        assign op_b[k] = (ex_q[k].op_b_sel == OPB_REG) ? ex_q[k].rs2_data : ex_q[k].imm;

        alu u_alu (
            .op_i     (ex_q[k].alu_op),
            .a_i      (ex_q[k].rs1_data),
            .b_i      (op_b[k]),
            .result_o (alu_res[k])
        );
    end

    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            wb_d[k].valid = ex_q[k].valid && ex_q[k].reg_write && (ex_q[k].rd != '0);
            wb_d[k].rd    = ex_q[k].rd;
            wb_d[k].data  = alu_res[k];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_q <= '0;
            wb_q <= '0;
        end else begin
            ex_q <= ex_d;
            wb_q <= wb_d;
        end
    end

    assign wb_o = wb_q;

endmodule

//--- verilog/issue_select.sv
`timescale 1ns/1ps

module issue_select (
    input  cpu_pkg::dec_vec_t    dec_i,
    input  cpu_pkg::issue_mask_t clear_i,
    output cpu_pkg::issue_mask_t issue_mask_o,
    output cpu_pkg::issue_cnt_t  issue_cnt_o
);
    import cpu_pkg::*;

    issue_mask_t ok;

    // raw and waw against every older slot in the group
    always_comb begin
        ok = clear_i;
        for (int k = 1; k < ISSUE_WIDTH; k++) begin
            for (int j = 0; j < k; j++) begin
                if (dec_i[j].reg_write && dec_i[j].rd != '0) begin
                    if (dec_i[k].reads_rs1 && dec_i[k].rs1 == dec_i[j].rd) begin
                        ok[k] = 1'b0;
                    end
                    if (dec_i[k].reads_rs2 && dec_i[k].rs2 == dec_i[j].rd) begin
                        ok[k] = 1'b0;
                    end
                    if (dec_i[k].reg_write && dec_i[k].rd == dec_i[j].rd) begin
                        ok[k] = 1'b0;
                    end
                end
            end
        end
    end

    // first blocked slot stops all later ones
    always_comb begin
        issue_mask_o[0] = ok[0];
        for (int k = 1; k < ISSUE_WIDTH; k++) begin
            issue_mask_o[k] = ok[k] && issue_mask_o[k-1];
        end
    end

    always_comb begin
        issue_cnt_o = '0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            issue_cnt_o = issue_cnt_o + issue_cnt_t'(issue_mask_o[k]);
        end
    end

    // pc advance by count only works for a prefix mask
    always_comb begin
        a_prefix: assert ((issue_mask_o & (issue_mask_o + 1'b1)) == '0)
            else $error("issue mask is not a prefix");
    end

endmodule

//--- verilog/scoreboard.sv
`timescale 1ns/1ps

module scoreboard (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_pkg::dec_vec_t    dec_i,
    input  cpu_pkg::issue_mask_t issue_mask_i,
    output cpu_pkg::issue_mask_t clear_o
);
    import cpu_pkg::*;

    logic [NUM_REGS-1:0] issue_set;
    logic [NUM_REGS-1:0] ex_busy_q;
    logic [NUM_REGS-1:0] wb_busy_q;
    logic [NUM_REGS-1:0] busy;

    // destinations of this cycle's issued writers
    always_comb begin
        issue_set = '0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            if (issue_mask_i[k] && dec_i[k].reg_write) begin
                issue_set[dec_i[k].rd] = 1'b1;
            end
        end
        issue_set[0] = 1'b0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_busy_q <= '0;
            wb_busy_q <= '0;
        end else begin
            ex_busy_q <= issue_set;
            wb_busy_q <= ex_busy_q;
        end
    end

    assign busy = ex_busy_q | wb_busy_q;

    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            clear_o[k] = !(dec_i[k].reads_rs1 && busy[dec_i[k].rs1])
                      && !(dec_i[k].reads_rs2 && busy[dec_i[k].rs2]);
        end
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                                             clk,
    input  logic                                             rst,
    input  cpu_pkg::reg_idx_t [cpu_pkg::ISSUE_WIDTH-1:0]     rs1_i,
    input  cpu_pkg::reg_idx_t [cpu_pkg::ISSUE_WIDTH-1:0]     rs2_i,
    output cpu_pkg::word_t    [cpu_pkg::ISSUE_WIDTH-1:0]     rs1_data_o,
    output cpu_pkg::word_t    [cpu_pkg::ISSUE_WIDTH-1:0]     rs2_data_o,
    input  cpu_pkg::wb_vec_t                                 wb_i
);
    import cpu_pkg::*;

    // x0 has no storage
    word_t regs_q [NUM_REGS-1:1];
    logic  dup_rd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (wb_i[k].valid) begin
                    regs_q[wb_i[k].rd] <= wb_i[k].data;
                end
            end
        end
    end

    // no bypass, writes show up next cycle
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            rs1_data_o[k] = (rs1_i[k] == '0) ? '0 : regs_q[rs1_i[k]];
            rs2_data_o[k] = (rs2_i[k] == '0) ? '0 : regs_q[rs2_i[k]];
        end
    end

    always_comb begin
        dup_rd = 1'b0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            for (int j = i + 1; j < ISSUE_WIDTH; j++) begin
                if (wb_i[i].valid && wb_i[j].valid && wb_i[i].rd == wb_i[j].rd) begin
                    dup_rd = 1'b1;
                end
            end
        end
    end

    // the issue logic keeps same-rd writers out of one group
    a_no_dup_rd: assert property (@(posedge clk) disable iff (rst) !dup_rd)
        else $error("two writeback lanes target the same register");

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e op_i,
    input  cpu_pkg::word_t   a_i,
    input  cpu_pkg::word_t   b_i,
    output cpu_pkg::word_t   result_o
);
    import cpu_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = ($signed(a_i) < $signed(b_i));
    assign lt_unsigned = (a_i < b_i);

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = {31'b0, lt_signed};
            ALU_SLTU: result_o = {31'b0, lt_unsigned};
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> shamt;
            // arithmetic shift keeps the sign bit
            ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            default:  result_o = '0;
        endcase
    end

endmodule

//--- verilog/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
    input  cpu_pkg::insn_t insn_i,
    output cpu_pkg::dec_t  dec_o
);
    import cpu_pkg::*;

    opcode_t    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    logic       is_op;
    logic       is_op_imm;
    logic       f7_zero;
    logic       f7_alt;
    logic       legal;
    alu_op_e    alu_op;

    assign opcode    = insn_i[6:0];
    assign funct3    = insn_i[14:12];
    assign funct7    = insn_i[31:25];
    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign f7_zero   = (funct7 == 7'b0000000);
    assign f7_alt    = (funct7 == 7'b0100000);

    // op-imm funct7 bits are upper immediate bits that only shifts decode
    always_comb begin
        alu_op = ALU_ADD;
        legal  = 1'b1;
        case (funct3)
            F3_ADD_SUB: begin
                alu_op = (is_op && f7_alt) ? ALU_SUB : ALU_ADD;
                legal  = is_op_imm || f7_zero || f7_alt;
            end
            F3_SLL: begin
                alu_op = ALU_SLL;
                legal  = f7_zero;
            end
            F3_SLT: begin
                alu_op = ALU_SLT;
                legal  = is_op_imm || f7_zero;
            end
            F3_SLTU: begin
                alu_op = ALU_SLTU;
                legal  = is_op_imm || f7_zero;
            end
            F3_XOR: begin
                alu_op = ALU_XOR;
                legal  = is_op_imm || f7_zero;
            end
            F3_SRL_SRA: begin
                alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                legal  = f7_zero || f7_alt;
            end
            F3_OR: begin
                alu_op = ALU_OR;
                legal  = is_op_imm || f7_zero;
            end
            F3_AND: begin
                alu_op = ALU_AND;
                legal  = is_op_imm || f7_zero;
            end
        endcase
    end

    always_comb begin
        dec_o.rs1       = insn_i[19:15];
        dec_o.rs2       = insn_i[24:20];
        dec_o.rd        = insn_i[11:7];
        dec_o.imm       = {{20{insn_i[31]}}, insn_i[31:20]};
        dec_o.alu_op    = alu_op;
        dec_o.op_b_sel  = is_op ? OPB_REG : OPB_IMM;
        dec_o.reads_rs1 = 1'b0;
        dec_o.reads_rs2 = 1'b0;
        dec_o.reg_write = 1'b0;
        // anything else is a bubble that never blocks
        if ((is_op || is_op_imm) && legal) begin
            dec_o.reads_rs1 = 1'b1;
            dec_o.reads_rs2 = is_op;
            dec_o.reg_write = 1'b1;
        end
    end

endmodule

//--- verilog/cpu_pkg.sv
package cpu_pkg;

    localparam int ISSUE_WIDTH = 4;
    localparam int NUM_REGS    = 32;

    typedef logic [31:0] word_t;
    typedef logic [31:0] insn_t;
    // word addressed, one step per instruction
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;

    // addi x0, x0, 0
    localparam insn_t NOP_INSN = 32'h0000_0013;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    typedef enum logic {
        OPB_REG,
        OPB_IMM
    } operand_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        reg_idx_t     rd;
        logic         reads_rs1;
        logic         reads_rs2;
        logic         reg_write;
        operand_sel_e op_b_sel;
        alu_op_e      alu_op;
        word_t        imm;
    } dec_t;

    typedef struct packed {
        logic         valid;
        reg_idx_t     rd;
        logic         reg_write;
        operand_sel_e op_b_sel;
        alu_op_e      alu_op;
        word_t        imm;
        word_t        rs1_data;
        word_t        rs2_data;
    } ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef dec_t  [ISSUE_WIDTH-1:0] dec_vec_t;
    typedef wb_t   [ISSUE_WIDTH-1:0] wb_vec_t;
    typedef insn_t [ISSUE_WIDTH-1:0] insn_vec_t;
    typedef logic  [ISSUE_WIDTH-1:0] issue_mask_t;
    typedef logic  [2:0]             issue_cnt_t;

endpackage
